// File: Bender.yml
package:
  name: his_builder

sources:
  - files:
      - rtl/sifh_pkg.sv
      - rtl/his_sequencer.sv
      - rtl/his_accumulator.sv
      - rtl/his_readout.sv
      - rtl/his_builder_top.sv
  - target: simulation
    files:
      - sim/his_checker.sv
      - sim/tb_his_builder.sv

// File: rtl/his_accumulator.sv
`timescale 1ns/1ps

module his_accumulator
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 4
) (
    input  logic        clk,
    input  logic        res,
    input  logic        tag_valid,
    input  tagged_hit_t tag,
    input  logic        rd_en,
    input  bin_addr_t   rd_addr,
    output bin_word_t   rd_data,
    output logic        swap,
    output logic        his_num
);

    localparam int DEPTH = PIXEL_NUM * BIN_NUM;
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [COUNT_W-1:0] COUNT_MAX = '1;

    // two banks, his_num picks the one being filled
    logic [COUNT_W-1:0] bank_mem [2][DEPTH];

    logic [AW-1:0]      hit_addr;
    logic [AW-1:0]      clr_addr;
    logic [COUNT_W-1:0] hit_cur;
    logic [COUNT_W-1:0] hit_next;

    // write stage of the read-modify-write
    logic               wr_valid;
    logic               wr_bank;
    logic [AW-1:0]      wr_addr;
    logic [COUNT_W-1:0] wr_count;

    // bank under readout, latched on swap
    logic rd_bank;

    // bin count is a power of two, so pixel-major order is a plain concatenation
    assign hit_addr = AW'({tag.pixel, tag.bin});
    assign clr_addr = AW'({rd_addr.pixel, rd_addr.bin});

    always_comb begin
        // hit still sitting in the write stage
        if (wr_valid && wr_bank == his_num && wr_addr == hit_addr) begin
            hit_cur = wr_count;
        // location cleared by the readout this very cycle
        end else if (rd_en && rd_bank == his_num && clr_addr == hit_addr) begin
            hit_cur = '0;
        end else begin
            hit_cur = bank_mem[his_num][hit_addr];
        end
    end

    // saturating increment
    assign hit_next = (hit_cur == COUNT_MAX) ? hit_cur : hit_cur + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wr_valid <= 1'b0;
            swap     <= 1'b0;
            his_num  <= 1'b0;
            rd_bank  <= 1'b1;
        end else begin
            wr_valid <= tag_valid;
            // swap rides along with the write of the last hit
            swap     <= tag_valid && tag.last;
            if (tag_valid && tag.last) begin
                his_num <= ~his_num;
            end
            // finished bank goes to the readout
            if (swap) begin
                rd_bank <= ~his_num;
            end
        end
    end

    // bank of the hit travels with it, his_num may flip meanwhile
    always_ff @(posedge clk) begin
        if (tag_valid) begin
            wr_bank  <= his_num;
            wr_addr  <= hit_addr;
            wr_count <= hit_next;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < DEPTH; i++) begin
                    bank_mem[b][i] <= '0;
                end
            end
        end else begin
            if (wr_valid) begin
                bank_mem[wr_bank][wr_addr] <= wr_count;
            end
            // read and clear in one go
            if (rd_en) begin
                bank_mem[rd_bank][clr_addr] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data.pixel <= rd_addr.pixel;
            rd_data.bin   <= rd_addr.bin;
            rd_data.count <= bank_mem[rd_bank][clr_addr];
        end
    end

    // rd_bank may only flip under the final read of a sweep
    a_swap_rd: assert property (@(posedge clk) disable iff (!res)
        swap |-> !rd_en || clr_addr == AW'(DEPTH - 1));

    // hit writes and clears never share a bank
    a_bank_split: assert property (@(posedge clk) disable iff (!res)
        wr_valid && rd_en |-> wr_bank != rd_bank);

endmodule

// File: rtl/his_builder_top.sv
`timescale 1ns/1ps

module his_builder_top
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 4,
    parameter int DATA_NUM  = 2,
    parameter int ACQ_NUM   = 8
) (
    input  logic             clk,
    input  logic             res,
    input  logic             hit_valid,
    input  logic [BIN_W-1:0] hit_bin,
    output logic             out_valid,
    output bin_word_t        out_word,
    output logic             frame_done,
    output logic             his_num
);

    // sequencer to accumulator
    logic        tag_valid;
    tagged_hit_t tag;

    // accumulator and readout handshake
    logic      swap;
    logic      rd_en;
    bin_addr_t rd_addr;
    bin_word_t rd_data;

    his_sequencer #(
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) seq0 (
        .clk       (clk),
        .res       (res),
        .hit_valid (hit_valid),
        .hit_bin   (hit_bin),
        .tag_valid (tag_valid),
        .tag       (tag)
    );

    his_accumulator #(
        .PIXEL_NUM (PIXEL_NUM)
    ) acc0 (
        .clk       (clk),
        .res       (res),
        .tag_valid (tag_valid),
        .tag       (tag),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .swap      (swap),
        .his_num   (his_num)
    );

    his_readout #(
        .PIXEL_NUM (PIXEL_NUM)
    ) rdo0 (
        .clk        (clk),
        .res        (res),
        .swap       (swap),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .frame_done (frame_done)
    );

endmodule

// File: rtl/his_readout.sv
`timescale 1ns/1ps

module his_readout
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 4
) (
    input  logic      clk,
    input  logic      res,
    input  logic      swap,
    output logic      rd_en,
    output bin_addr_t rd_addr,
    input  bin_word_t rd_data,
    output logic      out_valid,
    output bin_word_t out_word,
    output logic      frame_done
);

    // read in flight, and whether it is the last one of the sweep
    logic rd_pend;
    logic last_pend;
    logic rd_final;

    assign rd_final = rd_en && rd_addr.pixel == PIX_W'(PIXEL_NUM - 1) && (&rd_addr.bin);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rd_en      <= 1'b0;
            rd_addr    <= '0;
            rd_pend    <= 1'b0;
            last_pend  <= 1'b0;
            out_valid  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            rd_pend    <= rd_en;
            last_pend  <= rd_final;
            out_valid  <= rd_pend;
            frame_done <= last_pend;
            // swap cycle arms the sweep, reads start on the next one
            if (swap) begin
                rd_en   <= 1'b1;
                rd_addr <= '0;
            end else if (rd_final) begin
                rd_en   <= 1'b0;
                rd_addr <= '0;
            end else if (rd_en) begin
                // bins ascending within a pixel
                if (&rd_addr.bin) begin
                    rd_addr.bin   <= '0;
                    rd_addr.pixel <= rd_addr.pixel + 1'b1;
                end else begin
                    rd_addr.bin <= rd_addr.bin + 1'b1;
                end
            end
        end
    end

    // word lines up with the delayed valid
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            out_word <= rd_data;
        end
    end

    // next swap may only meet the final read of a sweep
    a_swap_busy: assert property (@(posedge clk) disable iff (!res)
        swap |-> !rd_en || rd_final);

endmodule

// File: rtl/his_sequencer.sv
`timescale 1ns/1ps

module his_sequencer
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 4,
    parameter int DATA_NUM  = 2,
    parameter int ACQ_NUM   = 8
) (
    input  logic             clk,
    input  logic             res,
    input  logic             hit_valid,
    input  logic [BIN_W-1:0] hit_bin,
    output logic             tag_valid,
    output tagged_hit_t      tag
);

    localparam int IN_W  = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1;
    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    // hits within a pixel, pixels within an acquisition, acquisitions within a frame
    logic [IN_W-1:0]  in_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    seq_state_e       state;

    logic in_wrap;
    logic pix_wrap;
    logic acq_wrap;
    logic frame_wrap;

    assign in_wrap    = (in_cnt == IN_W'(DATA_NUM - 1));
    assign pix_wrap   = (pix_cnt == PIX_W'(PIXEL_NUM - 1));
    assign acq_wrap   = (acq_cnt == ACQ_W'(ACQ_NUM - 1));
    // current hit closes the frame
    assign frame_wrap = in_wrap && pix_wrap && acq_wrap;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            tag_valid <= 1'b0;
            in_cnt    <= '0;
            pix_cnt   <= '0;
            acq_cnt   <= '0;
            state     <= SEQ_IDLE;
        end else begin
            tag_valid <= hit_valid;
            // only a sampled hit moves the counters
            if (hit_valid) begin
                state <= frame_wrap ? SEQ_FRAME_END : SEQ_COUNT;
                if (in_wrap) begin
                    in_cnt <= '0;
                    if (pix_wrap) begin
                        pix_cnt <= '0;
                        acq_cnt <= acq_wrap ? '0 : acq_cnt + 1'b1;
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end else begin
                    in_cnt <= in_cnt + 1'b1;
                end
            end
        end
    end

    // stamp with the pixel index before it advances
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            tag.bin   <= hit_bin;
            tag.pixel <= pix_cnt;
            tag.last  <= frame_wrap;
        end
    end

    // counters stay inside their ranges
    a_cnt_range: assert property (@(posedge clk) disable iff (!res)
        in_cnt < DATA_NUM && pix_cnt < PIXEL_NUM && acq_cnt < ACQ_NUM);

    // outside a frame all counters sit at zero
    a_idle_zero: assert property (@(posedge clk) disable iff (!res)
        state != SEQ_COUNT |-> in_cnt == '0 && pix_cnt == '0 && acq_cnt == '0);

    // a frame lasts at least as long as one readout sweep
    a_frame_len: assert property (@(posedge clk) disable iff (!res)
        DATA_NUM * ACQ_NUM >= BIN_NUM);

endmodule

// File: rtl/sifh_pkg.sv
package sifh_pkg;

    // bin address width, 16 bins by default
    localparam int BIN_W = 4;
    localparam int BIN_NUM = 1 << BIN_W;

    // widest pixel index the struct fields can carry
    localparam int PIX_W = 5;

    // histogram counter width
    // counts saturate at all ones
    localparam int COUNT_W = 4;

    // sequencer states
    // idle only until the first hit after reset
    // frame_end holds from the last hit of a frame to the next hit
    typedef enum logic [1:0] {
        SEQ_IDLE      = 2'b00,
        SEQ_COUNT     = 2'b01,
        SEQ_FRAME_END = 2'b10
    } seq_state_e;

    // hit tagged with its pixel
    // last marks the final hit of a frame
    typedef struct packed {
        logic [BIN_W-1:0] bin;
        logic [PIX_W-1:0] pixel;
        logic             last;
    } tagged_hit_t;

    // read-and-clear address into the idle bank
    typedef struct packed {
        logic [PIX_W-1:0] pixel;
        logic [BIN_W-1:0] bin;
    } bin_addr_t;

    // one counter word, used on the read port and the output stream
    typedef struct packed {
        logic [PIX_W-1:0]   pixel;
        logic [BIN_W-1:0]   bin;
        logic [COUNT_W-1:0] count;
    } bin_word_t;

endpackage

// File: sim/his_checker.sv
`timescale 1ns/1ps

module his_checker
    import sifh_pkg::*;
#(
    parameter int PIXEL_NUM = 4,
    parameter int DATA_NUM  = 2,
    parameter int ACQ_NUM   = 8
) (
    input  logic             clk,
    input  logic             res,
    input  logic             hit_valid,
    input  logic [BIN_W-1:0] hit_bin,
    input  logic             out_valid,
    input  bin_word_t        out_word,
    input  logic             frame_done,
    input  logic             his_num,
    output int               frame_cnt,
    output int               err_cnt
);

    localparam int RD_LEN     = PIXEL_NUM * BIN_NUM;
    localparam int FRAME_HITS = PIXEL_NUM * DATA_NUM * ACQ_NUM;
    localparam int SAT        = (1 << COUNT_W) - 1;

    // histogram of the frame being filled
    int hist [RD_LEN];
    // counts of finished frames, in readout order
    int exp_q [$];
    int hit_idx;
    int word_idx;

    // one more hit on a counter, stuck at the top
    function automatic int count_hit(input int cur);
        return (cur >= SAT) ? SAT : cur + 1;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("** Error %s word %0d: expected 0x%0h, got 0x%0h", name, word_idx, exp, got);
        err_cnt++;
    endtask

    // own pixel counting from the hit order
    always @(posedge clk) begin
        int pix;
        int slot;
        if (!res) begin
            hit_idx = 0;
            for (int i = 0; i < RD_LEN; i++) begin
                hist[i] = 0;
            end
        end else if (hit_valid) begin
            pix = (hit_idx / DATA_NUM) % PIXEL_NUM;
            slot = pix * BIN_NUM + int'(hit_bin);
            hist[slot] = count_hit(hist[slot]);
            hit_idx++;
            // frame complete, freeze it for the readout
            if (hit_idx == FRAME_HITS) begin
                for (int i = 0; i < RD_LEN; i++) begin
                    exp_q.push_back(hist[i]);
                    hist[i] = 0;
                end
                hit_idx = 0;
            end
        end
    end

    always @(posedge clk) begin
        int exp_cnt;
        int exp_pix;
        int exp_bin;
        if (!res) begin
            word_idx = 0;
            frame_cnt = 0;
            err_cnt = 0;
        end else if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("extra output word with no finished frame pending");
                err_cnt++;
            end else begin
                exp_cnt = exp_q.pop_front();
                exp_pix = word_idx / BIN_NUM;
                exp_bin = word_idx % BIN_NUM;
                // bank flipped once per finished frame
                if (word_idx == 0 && his_num !== 1'((frame_cnt + 1) % 2)) begin
                    report_mismatch("his_num", (frame_cnt + 1) % 2, his_num);
                end
                if (out_word.pixel !== exp_pix[PIX_W-1:0]) begin
                    report_mismatch("out_word.pixel", exp_pix, out_word.pixel);
                end
                if (out_word.bin !== exp_bin[BIN_W-1:0]) begin
                    report_mismatch("out_word.bin", exp_bin, out_word.bin);
                end
                if (out_word.count !== exp_cnt[COUNT_W-1:0]) begin
                    report_mismatch("out_word.count", exp_cnt, out_word.count);
                end
                if (word_idx == RD_LEN - 1 && frame_done !== 1'b1) begin
                    $display("frame_done missing on the last word of frame %0d", frame_cnt);
                    err_cnt++;
                end else if (word_idx != RD_LEN - 1 && frame_done !== 1'b0) begin
                    $display("frame_done raised early at word %0d", word_idx);
                    err_cnt++;
                end
                word_idx++;
                if (word_idx == RD_LEN) begin
                    word_idx = 0;
                    frame_cnt++;
                end
            end
        end else begin
            // stream must run without holes
            if (word_idx != 0) begin
                $display("readout broke off after %0d of %0d words", word_idx, RD_LEN);
                err_cnt++;
                while (word_idx < RD_LEN && exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                    word_idx++;
                end
                word_idx = 0;
                frame_cnt++;
            end
            if (frame_done !== 1'b0) begin
                $display("frame_done raised without an output word");
                err_cnt++;
            end
        end
    end

endmodule

// File: sim/tb_his_builder.sv
`timescale 1ns/1ps

module tb_his_builder;
    import sifh_pkg::*;

    localparam int PIXEL_NUM  = 4;
    localparam int DATA_NUM   = 2;
    localparam int ACQ_NUM    = 8;
    localparam int FRAME_HITS = PIXEL_NUM * DATA_NUM * ACQ_NUM;
    localparam int RD_LEN     = PIXEL_NUM * BIN_NUM;
    localparam int MAX_GAP    = 3;

    // bin patterns
    localparam int PAT_SPARSE = 0;
    localparam int PAT_RANDOM = 1;
    localparam int PAT_PAIRS  = 2;
    localparam int PAT_SINGLE = 3;

    // four one-frame tests, three frames back to back, one frame with gaps
    localparam int TIMEOUT = 4 * (FRAME_HITS + 2 * RD_LEN)
                           + (3 * FRAME_HITS + 2 * RD_LEN)
                           + (FRAME_HITS * (MAX_GAP + 1) + 2 * RD_LEN) + 100;

    logic             clk;
    logic             res;
    logic             hit_valid;
    logic [BIN_W-1:0] hit_bin;
    logic             out_valid;
    bin_word_t        out_word;
    logic             frame_done;
    logic             his_num;

    int frame_cnt;
    int err_cnt;
    int tb_err;
    int frame_target;
    int pass_cnt;
    int fail_cnt;
    int cycle_cnt;

    his_builder_top #(
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) dut0 (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .frame_done (frame_done),
        .his_num    (his_num)
    );

    his_checker #(
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) chk0 (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .frame_done (frame_done),
        .his_num    (his_num),
        .frame_cnt  (frame_cnt),
        .err_cnt    (err_cnt)
    );

    always #10 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout after %0d cycles, readout did not complete", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic value_error(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        $display("** Error %s: expected 0x%0h, got 0x%0h", name, exp, got);
        tb_err++;
    endtask

    // outputs sampled away from the active edge
    task automatic check_idle_outputs();
        @(negedge clk);
        if (out_valid !== 1'b0) value_error("out_valid", 0, out_valid);
        if (frame_done !== 1'b0) value_error("frame_done", 0, frame_done);
        if (his_num !== 1'b0) value_error("his_num", 0, his_num);
    endtask

    // one full frame, hit order pixel within acquisition
    task automatic send_frame(input int pattern, input int max_gap);
        int pix;
        int acq;
        int b;
        int gap;
        for (int k = 0; k < FRAME_HITS; k++) begin
            pix = (k / DATA_NUM) % PIXEL_NUM;
            acq = k / (DATA_NUM * PIXEL_NUM);
            case (pattern)
                PAT_SPARSE: b = (k % 2) ? 5 : 0;
                PAT_RANDOM: b = $urandom % BIN_NUM;
                // same bin for all hits of a pixel visit
                PAT_PAIRS:  b = (acq * 3 + pix) % BIN_NUM;
                default:    b = 9;
            endcase
            @(posedge clk);
            hit_valid <= 1'b1;
            hit_bin   <= b[BIN_W-1:0];
            gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
            repeat (gap) begin
                @(posedge clk);
                hit_valid <= 1'b0;
            end
        end
        @(posedge clk);
        hit_valid <= 1'b0;
    endtask

    task automatic run_test(input int num, input string name, input int frames,
                            input int pattern, input int max_gap, input bit idle_check);
        int err_start;
        err_start = err_cnt + tb_err;
        if (idle_check) begin
            check_idle_outputs();
        end
        for (int f = 0; f < frames; f++) begin
            send_frame(pattern, max_gap);
        end
        frame_target += frames;
        wait (frame_cnt >= frame_target);
        @(posedge clk);
        if (err_cnt + tb_err == err_start) begin
            $display("test %0d %s: ok", num, name);
            pass_cnt++;
        end else begin
            $display("test %0d %s: %0d errors", num, name, err_cnt + tb_err - err_start);
            fail_cnt++;
        end
    endtask

    initial begin
        clk = 1'b0;
        res = 1'b0;
        hit_valid = 1'b0;
        hit_bin = '0;
        tb_err = 0;
        frame_target = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        cycle_cnt = 0;
        void'($urandom(66114));
        repeat (10) @(posedge clk);
        res <= 1'b1;
        run_test(1, "reset state", 1, PAT_SPARSE, 0, 1'b1);
        run_test(2, "random frame", 1, PAT_RANDOM, 0, 1'b0);
        run_test(3, "forwarding", 1, PAT_PAIRS, 0, 1'b0);
        run_test(4, "saturation", 1, PAT_SINGLE, 0, 1'b0);
        run_test(5, "bank toggling", 3, PAT_RANDOM, 0, 1'b0);
        run_test(6, "idle gaps", 1, PAT_RANDOM, MAX_GAP, 1'b0);
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
rtl/sifh_pkg.sv
rtl/his_sequencer.sv
rtl/his_accumulator.sv
rtl/his_readout.sv
rtl/his_builder_top.sv
sim/his_checker.sv
sim/tb_his_builder.sv
